// ==== cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN = 32;
	localparam logic [4:0] LINK_REG = 5'd30; // return address for jal.

	// instruction field positions
	localparam int F_OP_HI = 31;
	localparam int F_OP_LO = 25;
	localparam int F_RT_HI = 24;
	localparam int F_RT_LO = 20;
	localparam int F_RA_HI = 19;
	localparam int F_RA_LO = 15;
	localparam int F_RB_HI = 14; // also imm5.
	localparam int F_RB_LO = 10;
	localparam int F_SV_HI = 9;
	localparam int F_SV_LO = 8;
	localparam int F_FN_HI = 4;
	localparam int F_FN_LO = 0;
	localparam int F_IMM15_HI = 14;
	localparam int F_IMM20_HI = 19;
	localparam int F_IMM_LO = 0;

	localparam logic [6:0] OP_ALU = 7'h20;
	localparam logic [6:0] OP_SLLI = 7'h2a;
	localparam logic [6:0] OP_ADDI = 7'h28;
	localparam logic [6:0] OP_ORI = 7'h2c;
	localparam logic [6:0] OP_MOVI = 7'h22;
	localparam logic [6:0] OP_SETHI = 7'h23;
	localparam logic [6:0] OP_LWI = 7'h04;
	localparam logic [6:0] OP_SWI = 7'h14;
	localparam logic [6:0] OP_LW = 7'h1c;
	localparam logic [6:0] OP_BEQ = 7'h26;
	localparam logic [6:0] OP_JAL = 7'h24;

	localparam logic [4:0] FN_ADD = 5'b00000;
	localparam logic [4:0] FN_SUB = 5'b00001;
	localparam logic [4:0] FN_AND = 5'b00010;
	localparam logic [4:0] FN_XOR = 5'b00011;
	localparam logic [4:0] FN_OR = 5'b00100;

	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR = 3'd3;
	localparam logic [2:0] ALU_XOR = 3'd4;
	localparam logic [2:0] ALU_SLL = 3'd5;
	localparam logic [2:0] ALU_PASS = 3'd6; // movi and sethi.

	localparam logic [2:0] ALUSRC2_RBDATA = 3'd0;
	localparam logic [2:0] ALUSRC2_IMM = 3'd1;
	localparam logic [2:0] ALUSRC2_LSWI = 3'd2;
	localparam logic [2:0] ALUSRC2_LSW = 3'd3;
	localparam logic [2:0] ALUSRC2_BENX = 3'd4;

	localparam logic [2:0] IMM_5BIT_ZE = 3'd0;
	localparam logic [2:0] IMM_15BIT_SE = 3'd1;
	localparam logic [2:0] IMM_15BIT_ZE = 3'd2;
	localparam logic [2:0] IMM_20BIT_SE = 3'd3;
	localparam logic [2:0] IMM_20BIT_HI = 3'd4;

	localparam logic WRADDR_RT = 1'b0;
	localparam logic WRADDR_LP = 1'b1;

	localparam logic [1:0] WRREG_ALURESULT = 2'd0;
	localparam logic [1:0] WRREG_IMMDATA = 2'd1;
	localparam logic [1:0] WRREG_MEM = 2'd2;
	localparam logic [1:0] WRREG_PC = 2'd3;

endpackage

// ==== muxs.sv ====
`timescale 1ns/100ps
module muxs (
	input logic [1:0] sub_op_sv,
	input logic [cpu_pkg::XLEN-1:0] reg_rb_data,
	input logic [cpu_pkg::XLEN-1:0] reg_rt_data,
	input logic [4:0] reg_rt_addr,
	input logic [cpu_pkg::XLEN-1:0] alu_result,
	input logic [cpu_pkg::XLEN-1:0] mem_read_data,
	input logic [cpu_pkg::XLEN-1:0] return_pc,
	input logic [4:0] imm_5bit,
	input logic [14:0] imm_15bit,
	input logic [19:0] imm_20bit,
	input logic [2:0] select_alu_src2,
	input logic [2:0] select_imm_extend,
	input logic select_write_reg_addr,
	input logic [1:0] select_write_reg,
	output logic [cpu_pkg::XLEN-1:0] imm_extend,
	output logic [cpu_pkg::XLEN-1:0] alu_src2,
	output logic [4:0] write_reg_addr,
	output logic [cpu_pkg::XLEN-1:0] write_reg_data
);
	import cpu_pkg::*;

	always_comb begin
		case (select_imm_extend)
			IMM_5BIT_ZE: imm_extend = {27'b0, imm_5bit};
			IMM_15BIT_SE: imm_extend = {{17{imm_15bit[14]}}, imm_15bit};
			IMM_15BIT_ZE: imm_extend = {17'b0, imm_15bit};
			IMM_20BIT_SE: imm_extend = {{12{imm_20bit[19]}}, imm_20bit};
			IMM_20BIT_HI: imm_extend = {imm_20bit, 12'b0}; // sethi.
			default: imm_extend = '0;
		endcase
	end

	always_comb begin
		case (select_alu_src2)
			ALUSRC2_RBDATA: alu_src2 = reg_rb_data;
			ALUSRC2_IMM: alu_src2 = imm_extend;
			ALUSRC2_LSWI: alu_src2 = {{15{imm_15bit[14]}}, imm_15bit, 2'b00}; // word offset.
			ALUSRC2_LSW: alu_src2 = reg_rb_data << sub_op_sv;
			ALUSRC2_BENX: alu_src2 = reg_rt_data; // beq compares ra with rt.
			default: alu_src2 = '0;
		endcase
	end

	always_comb begin
		if (select_write_reg_addr == WRADDR_LP) begin
			write_reg_addr = LINK_REG;
		end else begin
			write_reg_addr = reg_rt_addr;
		end
	end

	always_comb begin
		case (select_write_reg)
			WRREG_ALURESULT: write_reg_data = alu_result;
			WRREG_IMMDATA: write_reg_data = imm_extend;
			WRREG_MEM: write_reg_data = mem_read_data;
			default: write_reg_data = return_pc; // jal link value.
		endcase
	end

	// decoder must only hand out defined codes, even for junk opcodes
	always_comb begin
		assert (select_alu_src2 inside {ALUSRC2_RBDATA, ALUSRC2_IMM, ALUSRC2_LSWI,
			ALUSRC2_LSW, ALUSRC2_BENX})
		else $error("muxs: undefined alu src2 select %0d", select_alu_src2);
		assert (select_imm_extend inside {IMM_5BIT_ZE, IMM_15BIT_SE, IMM_15BIT_ZE,
			IMM_20BIT_SE, IMM_20BIT_HI})
		else $error("muxs: undefined immediate select %0d", select_imm_extend);
	end

endmodule

// ==== decoder.sv ====
`timescale 1ns/100ps
module decoder (
	input logic [cpu_pkg::XLEN-1:0] instr,
	output logic [4:0] ra_addr,
	output logic [4:0] rb_addr,
	output logic [4:0] rt_addr,
	output logic [1:0] sub_op_sv,
	output logic [4:0] imm_5bit,
	output logic [14:0] imm_15bit,
	output logic [19:0] imm_20bit,
	output logic [2:0] alu_op,
	output logic [2:0] select_alu_src2,
	output logic [2:0] select_imm_extend,
	output logic select_write_reg_addr,
	output logic [1:0] select_write_reg,
	output logic is_load,
	output logic is_store,
	output logic is_branch,
	output logic is_jump,
	output logic writes_reg,
	output logic illegal
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [4:0] funct;

	assign opcode = instr[F_OP_HI:F_OP_LO];
	assign funct = instr[F_FN_HI:F_FN_LO];
	assign rt_addr = instr[F_RT_HI:F_RT_LO];
	assign ra_addr = instr[F_RA_HI:F_RA_LO];
	assign rb_addr = instr[F_RB_HI:F_RB_LO];
	assign imm_5bit = instr[F_RB_HI:F_RB_LO]; // shares the rb slot.
	assign sub_op_sv = instr[F_SV_HI:F_SV_LO];
	assign imm_15bit = instr[F_IMM15_HI:F_IMM_LO];
	assign imm_20bit = instr[F_IMM20_HI:F_IMM_LO];

	always_comb begin
		alu_op = ALU_ADD;
		select_alu_src2 = ALUSRC2_RBDATA;
		select_imm_extend = IMM_15BIT_SE;
		select_write_reg_addr = WRADDR_RT;
		select_write_reg = WRREG_ALURESULT;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		writes_reg = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_ALU: begin
				writes_reg = 1'b1;
				case (funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					default: begin
						writes_reg = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			OP_SLLI: begin
				alu_op = ALU_SLL;
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = IMM_5BIT_ZE;
				writes_reg = 1'b1;
			end
			OP_ADDI: begin
				select_alu_src2 = ALUSRC2_IMM;
				writes_reg = 1'b1;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = IMM_15BIT_ZE;
				writes_reg = 1'b1;
			end
			OP_MOVI, OP_SETHI: begin
				alu_op = ALU_PASS;
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = (opcode == OP_SETHI) ? IMM_20BIT_HI : IMM_20BIT_SE;
				select_write_reg = WRREG_IMMDATA;
				writes_reg = 1'b1;
			end
			OP_LWI, OP_LW: begin
				select_alu_src2 = (opcode == OP_LW) ? ALUSRC2_LSW : ALUSRC2_LSWI;
				select_write_reg = WRREG_MEM;
				is_load = 1'b1;
				writes_reg = 1'b1;
			end
			OP_SWI: begin
				select_alu_src2 = ALUSRC2_LSWI;
				is_store = 1'b1;
			end
			OP_BEQ: begin
				alu_op = ALU_SUB;
				select_alu_src2 = ALUSRC2_BENX;
				is_branch = 1'b1;
			end
			OP_JAL: begin
				select_write_reg_addr = WRADDR_LP;
				select_write_reg = WRREG_PC;
				is_jump = 1'b1;
				writes_reg = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps
module regfile (
	input logic clk,
	input logic rst_n,
	input logic [4:0] ra_addr,
	input logic [4:0] rb_addr,
	input logic [4:0] rt_addr,
	input logic we,
	input logic [4:0] waddr,
	input logic [cpu_pkg::XLEN-1:0] wdata,
	output logic [cpu_pkg::XLEN-1:0] ra_data,
	output logic [cpu_pkg::XLEN-1:0] rb_data,
	output logic [cpu_pkg::XLEN-1:0] rt_data
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [32];

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr]; // store data and beq compare.

	// r0 is an ordinary register here.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps
module alu (
	input logic [2:0] alu_op,
	input logic [cpu_pkg::XLEN-1:0] src1,
	input logic [cpu_pkg::XLEN-1:0] src2,
	output logic [cpu_pkg::XLEN-1:0] result,
	output logic equal
);
	import cpu_pkg::*;

	assign equal = (src1 == src2); // beq decision.

	always_comb begin
		case (alu_op)
			ALU_ADD: result = src1 + src2;
			ALU_SUB: result = src1 - src2;
			ALU_AND: result = src1 & src2;
			ALU_OR: result = src1 | src2;
			ALU_XOR: result = src1 ^ src2;
			ALU_SLL: result = src1 << src2[4:0];
			ALU_PASS: result = src2;
			default: result = '0;
		endcase
	end

endmodule

// ==== core_ctrl.sv ====
`timescale 1ns/100ps
module core_ctrl (
	input logic clk,
	input logic rst_n,
	input logic imem_ack,
	input logic [cpu_pkg::XLEN-1:0] imem_rdata,
	input logic dmem_ack,
	input logic [cpu_pkg::XLEN-1:0] dmem_rdata,
	input logic is_load,
	input logic is_store,
	input logic is_branch,
	input logic is_jump,
	input logic writes_reg,
	input logic illegal,
	input logic equal,
	input logic [cpu_pkg::XLEN-1:0] alu_result,
	input logic [cpu_pkg::XLEN-1:0] rt_data,
	input logic [14:0] imm_15bit,
	input logic [19:0] imm_20bit,
	output logic imem_req,
	output logic [cpu_pkg::XLEN-1:0] imem_addr,
	output logic dmem_req,
	output logic dmem_we,
	output logic [cpu_pkg::XLEN-1:0] dmem_addr,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata,
	output logic [cpu_pkg::XLEN-1:0] instr,
	output logic [cpu_pkg::XLEN-1:0] return_pc,
	output logic [cpu_pkg::XLEN-1:0] load_data,
	output logic reg_we
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		S_FETCH,
		S_FWAIT,
		S_EXEC,
		S_MEM,
		S_MWAIT,
		S_WB
	} state_t;

	state_t state;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_next;

	// imem_addr is the pc itself.
	assign pc_plus4 = imem_addr + XLEN'(4);
	assign reg_we = (state == S_WB);

	always_comb begin
		if (is_jump) begin
			pc_next = imem_addr + {{10{imm_20bit[19]}}, imm_20bit, 2'b00};
		end else if (is_branch && equal) begin
			pc_next = imem_addr + {{15{imm_15bit[14]}}, imm_15bit, 2'b00};
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_FETCH;
			imem_req <= 1'b0;
			imem_addr <= '0;
			dmem_req <= 1'b0;
			dmem_we <= 1'b0;
			instr <= '0;
		end else begin
			case (state)
				S_FETCH: begin
					if (!imem_req && !imem_ack) begin
						imem_req <= 1'b1;
					end else if (imem_req && imem_ack) begin
						instr <= imem_rdata;
						imem_req <= 1'b0;
						state <= S_FWAIT;
					end
				end
				S_FWAIT: begin
					if (!imem_ack) begin
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					imem_addr <= pc_next;
					if (is_load || is_store) begin
						dmem_we <= is_store;
						state <= S_MEM;
					end else if (writes_reg) begin
						state <= S_WB;
					end else begin
						state <= S_FETCH; // branch or dropped opcode.
					end
				end
				S_MEM: begin
					if (!dmem_req && !dmem_ack) begin
						dmem_req <= 1'b1;
					end else if (dmem_req && dmem_ack) begin
						dmem_req <= 1'b0;
						dmem_we <= 1'b0;
						state <= S_MWAIT;
					end
				end
				S_MWAIT: begin
					if (!dmem_ack) begin
						state <= is_load ? S_WB : S_FETCH;
					end
				end
				default: state <= S_FETCH; // S_WB lasts one cycle.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_EXEC) begin
			dmem_addr <= alu_result;
			dmem_wdata <= rt_data;
			return_pc <= pc_plus4;
		end
		if (state == S_MEM && dmem_req && dmem_ack) begin
			load_data <= dmem_rdata;
		end
	end

	a_imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		imem_req && !imem_ack |=> imem_req && $stable(imem_addr));

	a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_req && !dmem_ack |=> dmem_req && $stable({dmem_we, dmem_addr, dmem_wdata}));

	a_no_illegal: assert property (@(posedge clk) disable iff (!rst_n)
		state == S_EXEC |-> !illegal);

endmodule

// ==== nds_core.sv ====
`timescale 1ns/100ps
module nds_core (
	input logic clk,
	input logic rst_n,
	output logic imem_req,
	output logic [cpu_pkg::XLEN-1:0] imem_addr,
	input logic imem_ack,
	input logic [cpu_pkg::XLEN-1:0] imem_rdata,
	output logic dmem_req,
	output logic dmem_we,
	output logic [cpu_pkg::XLEN-1:0] dmem_addr,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata,
	input logic dmem_ack,
	input logic [cpu_pkg::XLEN-1:0] dmem_rdata,
	output logic wb_valid,
	output logic [4:0] wb_addr,
	output logic [cpu_pkg::XLEN-1:0] wb_data
);
	import cpu_pkg::*;

	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] return_pc;
	logic [XLEN-1:0] load_data;
	logic [4:0] ra_addr;
	logic [4:0] rb_addr;
	logic [4:0] rt_addr;
	logic [1:0] sub_op_sv;
	logic [4:0] imm_5bit;
	logic [14:0] imm_15bit;
	logic [19:0] imm_20bit;
	logic [2:0] alu_op;
	logic [2:0] select_alu_src2;
	logic [2:0] select_imm_extend;
	logic select_write_reg_addr;
	logic [1:0] select_write_reg;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic is_jump;
	logic writes_reg;
	logic illegal;
	logic [XLEN-1:0] ra_data;
	logic [XLEN-1:0] rb_data;
	logic [XLEN-1:0] rt_data;
	logic [XLEN-1:0] alu_src2;
	logic [XLEN-1:0] alu_result;
	logic equal;

	core_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata),
		.is_load(is_load),
		.is_store(is_store),
		.is_branch(is_branch),
		.is_jump(is_jump),
		.writes_reg(writes_reg),
		.illegal(illegal),
		.equal(equal),
		.alu_result(alu_result),
		.rt_data(rt_data),
		.imm_15bit(imm_15bit),
		.imm_20bit(imm_20bit),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.instr(instr),
		.return_pc(return_pc),
		.load_data(load_data),
		.reg_we(wb_valid)
	);

	decoder u_dec (
		.instr(instr),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.sub_op_sv(sub_op_sv),
		.imm_5bit(imm_5bit),
		.imm_15bit(imm_15bit),
		.imm_20bit(imm_20bit),
		.alu_op(alu_op),
		.select_alu_src2(select_alu_src2),
		.select_imm_extend(select_imm_extend),
		.select_write_reg_addr(select_write_reg_addr),
		.select_write_reg(select_write_reg),
		.is_load(is_load),
		.is_store(is_store),
		.is_branch(is_branch),
		.is_jump(is_jump),
		.writes_reg(writes_reg),
		.illegal(illegal)
	);

	regfile u_rf (
		.clk(clk),
		.rst_n(rst_n),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.we(wb_valid),
		.waddr(wb_addr),
		.wdata(wb_data),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.rt_data(rt_data)
	);

	alu u_alu (
		.alu_op(alu_op),
		.src1(ra_data),
		.src2(alu_src2),
		.result(alu_result),
		.equal(equal)
	);

	muxs u_muxs (
		.sub_op_sv(sub_op_sv),
		.reg_rb_data(rb_data),
		.reg_rt_data(rt_data),
		.reg_rt_addr(rt_addr),
		.alu_result(alu_result),
		.mem_read_data(load_data),
		.return_pc(return_pc),
		.imm_5bit(imm_5bit),
		.imm_15bit(imm_15bit),
		.imm_20bit(imm_20bit),
		.select_alu_src2(select_alu_src2),
		.select_imm_extend(select_imm_extend),
		.select_write_reg_addr(select_write_reg_addr),
		.select_write_reg(select_write_reg),
		.imm_extend(),
		.alu_src2(alu_src2),
		.write_reg_addr(wb_addr),
		.write_reg_data(wb_data)
	);

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/100ps
module tb_checker (
	input logic clk,
	input logic rst_n,
	input logic imem_req,
	input logic [cpu_pkg::XLEN-1:0] imem_addr,
	input logic imem_ack,
	input logic [cpu_pkg::XLEN-1:0] imem_rdata,
	input logic dmem_req,
	input logic dmem_we,
	input logic [cpu_pkg::XLEN-1:0] dmem_addr,
	input logic [cpu_pkg::XLEN-1:0] dmem_wdata,
	input logic dmem_ack,
	input logic wb_valid,
	input logic [4:0] wb_addr,
	input logic [cpu_pkg::XLEN-1:0] wb_data,
	output logic done,
	output int errors
);
	import cpu_pkg::*;

	logic [31:0] mrf [32];
	logic [31:0] mmem [64];
	logic [31:0] mpc;
	logic [31:0] last_fetch;
	logic fetched;
	logic rst_seen;
	logic [1:0] since_rst;
	logic pend_wb;
	logic pend_mem;
	logic [4:0] exp_waddr;
	logic [31:0] exp_wdata;
	logic exp_we;
	logic [31:0] exp_maddr;
	logic [31:0] exp_mwdata;
	logic prev_ireq;
	logic prev_dreq;
	logic [31:0] prev_iaddr;
	logic [64:0] prev_dreq_sig;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("[ERROR] %0t %s", $time, what);
		errors++;
	endtask

	// ISA model stepping one instruction per call.
	function automatic void step(input logic [31:0] ins);
		logic [6:0] op;
		logic [4:0] rt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic [31:0] s15;
		logic [31:0] s20;
		logic [31:0] next_pc;
		op = ins[31:25];
		rt = ins[24:20];
		a = mrf[ins[19:15]];
		b = mrf[ins[14:10]];
		t = mrf[rt];
		s15 = {{17{ins[14]}}, ins[14:0]};
		s20 = {{12{ins[19]}}, ins[19:0]};
		next_pc = mpc + 32'd4;
		pend_wb = 1'b1;
		pend_mem = 1'b0;
		exp_waddr = rt;
		exp_wdata = '0;
		case (op)
			OP_ALU: begin
				case (ins[4:0])
					FN_ADD: exp_wdata = a + b;
					FN_SUB: exp_wdata = a - b;
					FN_AND: exp_wdata = a & b;
					FN_OR: exp_wdata = a | b;
					default: exp_wdata = a ^ b;
				endcase
			end
			OP_SLLI: exp_wdata = a << ins[14:10];
			OP_ADDI: exp_wdata = a + s15;
			OP_ORI: exp_wdata = a | {17'b0, ins[14:0]};
			OP_MOVI: exp_wdata = s20;
			OP_SETHI: exp_wdata = 32'(ins[19:0]) << 12;
			OP_LWI, OP_SWI, OP_LW: begin
				pend_mem = 1'b1;
				exp_we = (op == OP_SWI);
				exp_maddr = (op == OP_LW) ? a + (b << ins[9:8]) : a + (s15 << 2);
				exp_mwdata = t;
				if (op == OP_SWI) begin
					mmem[exp_maddr[7:2]] = t;
					pend_wb = 1'b0;
				end
				exp_wdata = mmem[exp_maddr[7:2]];
			end
			OP_BEQ: begin
				pend_wb = 1'b0;
				if (a == t) next_pc = mpc + (s15 << 2);
			end
			default: begin // jal.
				exp_waddr = LINK_REG;
				exp_wdata = mpc + 32'd4;
				next_pc = mpc + (s20 << 2);
			end
		endcase
		if (pend_wb) mrf[exp_waddr] = exp_wdata;
		mpc = next_pc;
	endfunction

	initial begin
		done = 1'b0;
		errors = 0;
		rst_seen = 1'b0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			if (rst_seen) begin
				check_value("imem_req", {31'b0, imem_req}, 32'd0);
				check_value("dmem_req", {31'b0, dmem_req}, 32'd0);
				check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
			end
			rst_seen = 1'b1;
			since_rst = 2'd0;
			for (int i = 0; i < 32; i++) mrf[i] = '0;
			for (int i = 0; i < 64; i++) mmem[i] = '0;
			mpc = '0;
			fetched = 1'b0;
			pend_wb = 1'b0;
			pend_mem = 1'b0;
			prev_ireq = 1'b0;
			prev_dreq = 1'b0;
		end else begin
			if (since_rst == 2'd0) begin
				check_value("imem_req", {31'b0, imem_req}, 32'd0);
				check_value("dmem_req", {31'b0, dmem_req}, 32'd0);
				check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
				since_rst = 2'd1;
			end else if (since_rst == 2'd1) begin
				check_value("imem_req", {31'b0, imem_req}, 32'd1); // first fetch request.
				since_rst = 2'd2;
			end
			if (imem_req && !prev_ireq) begin
				if (imem_ack) report_problem("imem_req rose while imem_ack was still high");
				if (pend_wb) report_problem("write-back pulse missing before next fetch");
				if (pend_mem) report_problem("data request missing before next fetch");
				check_value("imem_addr", imem_addr, mpc);
				if (fetched && imem_addr == last_fetch) done = 1'b1; // self-loop.
				last_fetch = imem_addr;
				fetched = 1'b1;
			end
			if (imem_req && prev_ireq && imem_addr !== prev_iaddr)
				report_problem("imem_addr changed while imem_req was high");
			if (imem_req && imem_ack && !done) step(imem_rdata);
			if (dmem_req && !prev_dreq) begin
				if (dmem_ack) report_problem("dmem_req rose while dmem_ack was still high");
				if (!pend_mem) report_problem("unexpected data request");
				check_value("dmem_we", {31'b0, dmem_we}, {31'b0, exp_we});
				check_value("dmem_addr", dmem_addr, exp_maddr);
				if (exp_we) check_value("dmem_wdata", dmem_wdata, exp_mwdata);
				pend_mem = 1'b0;
			end
			if (dmem_req && prev_dreq && {dmem_we, dmem_addr, dmem_wdata} !== prev_dreq_sig)
				report_problem("data request signals changed while dmem_req was high");
			if (wb_valid) begin
				if (!pend_wb) report_problem("extra write-back pulse for one instruction");
				check_value("wb_addr", {27'b0, wb_addr}, {27'b0, exp_waddr});
				check_value("wb_data", wb_data, exp_wdata);
				pend_wb = 1'b0;
			end
			prev_ireq = imem_req;
			prev_iaddr = imem_addr;
			prev_dreq = dmem_req;
			prev_dreq_sig = {dmem_we, dmem_addr, dmem_wdata};
		end
	end

endmodule

// ==== tb_nds_core.sv ====
`timescale 1ns/100ps
module tb_nds_core;
	import cpu_pkg::*;

	localparam int PROG_LEN = 27;

	logic clk;
	logic rst_n;
	logic imem_req;
	logic [31:0] imem_addr;
	logic imem_ack;
	logic [31:0] imem_rdata;
	logic dmem_req;
	logic dmem_we;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic dmem_ack;
	logic [31:0] dmem_rdata;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic done;
	int errors;
	logic timed_out;
	logic [31:0] prog [32];
	logic [31:0] dmem [64];
	logic [31:0] lfsr;
	logic [2:0] idelay;
	logic [2:0] icnt;
	logic [2:0] ddelay;
	logic [2:0] dcnt;

	nds_core dut_i (.*);

	tb_checker checker_i (.*);

	always #10 clk = ~clk;

	// galois lfsr stepped once per delay bit.
	function automatic logic [2:0] rand_delay(inout logic [31:0] s);
		logic [2:0] v;
		v = '0;
		for (int i = 0; i < 3; i++) begin
			v = {v[1:0], s[0]};
			s = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] r_form(input logic [6:0] op, input logic [4:0] fn,
		input logic [4:0] rt, input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv);
		return {op, rt, ra, rb, sv, 3'b000, fn};
	endfunction

	function automatic logic [31:0] i_form(input logic [6:0] op, input logic [4:0] rt,
		input logic [4:0] ra, input logic [14:0] imm);
		return {op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] u_form(input logic [6:0] op, input logic [4:0] rt,
		input logic [19:0] imm);
		return {op, rt, imm};
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			imem_ack <= 1'b0;
			dmem_ack <= 1'b0;
			icnt <= '0;
			dcnt <= '0;
			idelay <= rand_delay(lfsr);
			ddelay <= rand_delay(lfsr);
		end else begin
			if (imem_req && !imem_ack) begin
				if (icnt == idelay) begin
					imem_ack <= 1'b1;
					imem_rdata <= prog[imem_addr[6:2]];
					icnt <= '0;
				end else icnt <= icnt + 3'd1;
			end else if (!imem_req && imem_ack) begin
				imem_ack <= 1'b0;
				idelay <= rand_delay(lfsr);
			end
			if (dmem_req && !dmem_ack) begin
				if (dcnt == ddelay) begin
					dmem_ack <= 1'b1;
					if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
					else dmem_rdata <= dmem[dmem_addr[7:2]];
					dcnt <= '0;
				end else dcnt <= dcnt + 3'd1;
			end else if (!dmem_req && dmem_ack) begin
				dmem_ack <= 1'b0;
				ddelay <= rand_delay(lfsr);
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		imem_ack = 1'b0;
		imem_rdata = '0;
		dmem_ack = 1'b0;
		dmem_rdata = '0;
		lfsr = 32'hcf0b;
		for (int i = 0; i < 32; i++) prog[i] = '0;
		for (int i = 0; i < 64; i++) dmem[i] = '0;
		prog[0] = u_form(OP_MOVI, 5'd1, 20'd5);
		prog[1] = u_form(OP_MOVI, 5'd2, 20'hffffd);
		prog[2] = u_form(OP_SETHI, 5'd3, 20'h12345);
		prog[3] = r_form(OP_ALU, FN_ADD, 5'd4, 5'd1, 5'd2, 2'd0);
		prog[4] = r_form(OP_ALU, FN_SUB, 5'd5, 5'd1, 5'd2, 2'd0);
		prog[5] = r_form(OP_ALU, FN_AND, 5'd6, 5'd3, 5'd2, 2'd0);
		prog[6] = r_form(OP_ALU, FN_OR, 5'd7, 5'd3, 5'd1, 2'd0);
		prog[7] = r_form(OP_ALU, FN_XOR, 5'd8, 5'd3, 5'd2, 2'd0);
		prog[8] = i_form(OP_SLLI, 5'd9, 5'd1, 15'h1c00); // shift by 7.
		prog[9] = i_form(OP_ADDI, 5'd10, 5'd1, 15'h7f9c);
		prog[10] = i_form(OP_ORI, 5'd11, 5'd3, 15'h7abc);
		prog[11] = u_form(OP_MOVI, 5'd12, 20'd16); // data base.
		prog[12] = i_form(OP_SWI, 5'd7, 5'd12, 15'd1);
		prog[13] = i_form(OP_SWI, 5'd8, 5'd12, 15'h7fff);
		prog[14] = i_form(OP_LWI, 5'd13, 5'd12, 15'd1);
		prog[15] = i_form(OP_LWI, 5'd19, 5'd12, 15'h7fff);
		prog[16] = u_form(OP_MOVI, 5'd14, 20'd4);
		prog[17] = r_form(OP_LW, 5'd0, 5'd15, 5'd12, 5'd14, 2'd0);
		prog[18] = r_form(OP_LW, 5'd0, 5'd16, 5'd12, 5'd14, 2'd1);
		prog[19] = r_form(OP_LW, 5'd0, 5'd17, 5'd12, 5'd14, 2'd2);
		prog[20] = r_form(OP_LW, 5'd0, 5'd18, 5'd12, 5'd14, 2'd3);
		prog[21] = i_form(OP_BEQ, 5'd2, 5'd1, 15'd2); // not taken.
		prog[22] = i_form(OP_BEQ, 5'd7, 5'd13, 15'd2); // taken.
		prog[23] = u_form(OP_MOVI, 5'd20, 20'h77);
		prog[24] = u_form(OP_JAL, 5'd0, 20'd2);
		prog[25] = u_form(OP_MOVI, 5'd21, 20'h66);
		prog[26] = i_form(OP_BEQ, 5'd0, 5'd0, 15'd0); // self-loop.
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait (done || timed_out);
		$display("run finished: %0d errors, %0d timeouts", errors, timed_out ? 1 : 0);
		if (errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		timed_out = 1'b0;
		repeat (PROG_LEN * 40) @(posedge clk);
		if (!done) begin
			$display("timeout: the program did not reach its closing loop in time");
			timed_out = 1'b1;
		end
	end

endmodule

// ==== nds_core.f ====
cpu_pkg.sv
muxs.sv
decoder.sv
regfile.sv
alu.sv
core_ctrl.sv
nds_core.sv
tb_checker.sv
tb_nds_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_nds_core -f nds_core.f -o tb_nds_core
	./obj_dir/tb_nds_core | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
